// File: rtl/vid_mm_pkg.sv
/*
 * shared widths, vector typedefs, memory channel structs
 * and FSM state enums of the frame buffer path
 */
`default_nettype none

package vid_mm_pkg;

    // pixel and memory word geometry
    localparam int PIX_W        = 16;
    localparam int WORD_W       = 64;
    localparam int PIX_PER_WORD = WORD_W / PIX_W;
    // word address and burst length widths
    localparam int ADDR_W       = 12;
    localparam int BLEN_W       = 8;

    typedef logic [PIX_W-1:0]                pix_t;
    typedef logic [WORD_W-1:0]               word_t;
    typedef logic [$clog2(PIX_PER_WORD)-1:0] lane_t;
    typedef logic [ADDR_W-1:0]               addr_t;
    // number of beats, not beats minus one
    typedef logic [BLEN_W-1:0]               blen_t;

    typedef struct packed {
        addr_t addr;
        blen_t len;
    } mm_aw_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } mm_w_t;

    typedef struct packed {
        addr_t addr;
        blen_t len;
    } mm_ar_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } mm_r_t;

    typedef enum logic [1:0] {wr_idle, wr_addr, wr_data} wr_state_t;
    typedef enum logic [1:0] {rd_idle, rd_addr, rd_data} rd_state_t;

endpackage

`default_nettype wire

// File: rtl/pixel_packer.sv
/*
 * pixel_packer: gathers raster pixels into memory words
 * and turns vsync into a registered frame start
 */
`timescale 1ns/1ns
`default_nettype none

module pixel_packer (
    input  wire                    mm_tras_inst,
    input  wire                    rst_n,
    input  wire                    vsync,
    input  wire                    de,
    input  wire vid_mm_pkg::pix_t  pix,
    output logic                   word_valid,
    output vid_mm_pkg::word_t      word,
    output logic                   frame_start
);

    vid_mm_pkg::lane_t lane;
    vid_mm_pkg::word_t asm_word;
    logic              lane_full;

    // last lane of the word being filled
    assign lane_full = (lane == vid_mm_pkg::lane_t'(vid_mm_pkg::PIX_PER_WORD - 1));

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            lane        <= '0;
            word_valid  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= vsync;
            word_valid  <= 1'b0;
            if (vsync) begin
                // partial word of the old frame is dropped
                lane <= '0;
            end else if (de) begin
                lane       <= lane + 1'b1;
                word_valid <= lane_full;
            end
        end
    end

    // lane 0 lands in the low bits
    always_ff @(posedge mm_tras_inst) begin
        if (de && !vsync) begin
            asm_word[lane * vid_mm_pkg::PIX_W +: vid_mm_pkg::PIX_W] <= pix;
        end
    end

    // full word stays intact for the cycle after the last lane
    assign word = asm_word;

endmodule

`default_nettype wire

// File: rtl/burst_writer.sv
/*
 * burst_writer: circular word queue and write burst FSM
 * with frame restart of the address and sticky overflow
 */
`timescale 1ns/1ns
`default_nettype none

module burst_writer #(
    parameter int BURST_LEN   = 4,
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                     mm_tras_inst,
    input  wire                     rst_n,
    input  wire                     word_valid,
    input  wire vid_mm_pkg::word_t  word,
    input  wire                     frame_start,
    input  wire                     aw_ready,
    input  wire                     w_ready,
    output logic                    aw_valid,
    output vid_mm_pkg::mm_aw_t      aw,
    output logic                    w_valid,
    output vid_mm_pkg::mm_w_t       w,
    output logic                    overflow
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    vid_mm_pkg::word_t     queue [QUEUE_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  full;
    logic                  push;
    logic                  pop;
    vid_mm_pkg::wr_state_t state;
    vid_mm_pkg::addr_t     cur_addr;
    vid_mm_pkg::blen_t     beat_cnt;
    logic                  restart_pend;

    assign full = (count == CNT_W'(QUEUE_DEPTH));
    assign push = word_valid && !full;
    assign pop  = w_valid && w_ready;

    assign aw_valid = (state == vid_mm_pkg::wr_addr);
    assign w_valid  = (state == vid_mm_pkg::wr_data);
    assign aw       = '{addr: cur_addr, len: vid_mm_pkg::blen_t'(BURST_LEN)};
    // head word is held until its beat is taken
    assign w        = '{data: queue[rd_ptr],
                        last: (beat_cnt == vid_mm_pkg::blen_t'(BURST_LEN - 1))};

    always_ff @(posedge mm_tras_inst) begin
        if (push) begin
            queue[wr_ptr] <= word;
        end
    end

    // queue pointers, fill level, overflow
    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (word_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // burst FSM
    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            state        <= vid_mm_pkg::wr_idle;
            cur_addr     <= '0;
            beat_cnt     <= '0;
            restart_pend <= 1'b0;
        end else begin
            case (state)
                vid_mm_pkg::wr_idle: begin
                    beat_cnt <= '0;
                    // restart applies only between bursts
                    if (frame_start || restart_pend) begin
                        cur_addr     <= '0;
                        restart_pend <= 1'b0;
                    end
                    if (count >= CNT_W'(BURST_LEN)) begin
                        state <= vid_mm_pkg::wr_addr;
                    end
                end
                vid_mm_pkg::wr_addr: begin
                    if (frame_start) begin
                        restart_pend <= 1'b1;
                    end
                    if (aw_ready) begin
                        state <= vid_mm_pkg::wr_data;
                    end
                end
                default: begin
                    if (frame_start) begin
                        restart_pend <= 1'b1;
                    end
                    if (pop) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (w.last) begin
                            cur_addr <= cur_addr + vid_mm_pkg::addr_t'(BURST_LEN);
                            state    <= vid_mm_pkg::wr_idle;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/burst_reader.sv
/*
 * burst_reader: read burst FSM with address wrap at the
 * frame size, and the circular buffer of returned words
 */
`timescale 1ns/1ns
`default_nettype none

module burst_reader #(
    parameter int BURST_LEN   = 4,
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                     mm_tras_inst,
    input  wire                     rst_n,
    input  wire                     rd_enable,
    input  wire vid_mm_pkg::addr_t  frame_words,
    input  wire                     ar_ready,
    input  wire                     r_valid,
    input  wire vid_mm_pkg::mm_r_t  r,
    input  wire                     buf_pop,
    output logic                    ar_valid,
    output vid_mm_pkg::mm_ar_t      ar,
    output logic                    r_ready,
    output logic                    buf_valid,
    output vid_mm_pkg::word_t       buf_word
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    vid_mm_pkg::word_t         rbuf [QUEUE_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      space_ok;
    logic                      push;
    vid_mm_pkg::rd_state_t     state;
    vid_mm_pkg::addr_t         cur_addr;
    logic [vid_mm_pkg::ADDR_W:0] next_addr;

    // a whole burst must fit before it is requested
    assign space_ok  = (CNT_W'(QUEUE_DEPTH) - count) >= CNT_W'(BURST_LEN);
    assign push      = r_valid && r_ready;
    // one extra bit so the wrap compare cannot overflow
    assign next_addr = {1'b0, cur_addr} + (vid_mm_pkg::ADDR_W + 1)'(BURST_LEN);

    assign ar_valid  = (state == vid_mm_pkg::rd_addr);
    assign r_ready   = (state == vid_mm_pkg::rd_data);
    assign ar        = '{addr: cur_addr, len: vid_mm_pkg::blen_t'(BURST_LEN)};
    assign buf_valid = (count != '0);
    assign buf_word  = rbuf[rd_ptr];

    always_ff @(posedge mm_tras_inst) begin
        if (push) begin
            rbuf[wr_ptr] <= r.data;
        end
    end

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (buf_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, buf_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // read burst FSM
    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            state    <= vid_mm_pkg::rd_idle;
            cur_addr <= '0;
        end else begin
            case (state)
                vid_mm_pkg::rd_idle: begin
                    if (rd_enable && space_ok) begin
                        state <= vid_mm_pkg::rd_addr;
                    end
                end
                vid_mm_pkg::rd_addr: begin
                    if (ar_ready) begin
                        state <= vid_mm_pkg::rd_data;
                    end
                end
                default: begin
                    if (push && r.last) begin
                        state <= vid_mm_pkg::rd_idle;
                        // back to frame start once the region is read out
                        if (next_addr >= {1'b0, frame_words}) begin
                            cur_addr <= '0;
                        end else begin
                            cur_addr <= next_addr[vid_mm_pkg::ADDR_W-1:0];
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/pixel_unpacker.sv
/*
 * pixel_unpacker: splits buffered words into a valid/ready
 * pixel stream, lane 0 first
 */
`timescale 1ns/1ns
`default_nettype none

module pixel_unpacker (
    input  wire                     mm_tras_inst,
    input  wire                     rst_n,
    input  wire                     buf_valid,
    input  wire vid_mm_pkg::word_t  buf_word,
    input  wire                     out_ready,
    output logic                    buf_pop,
    output logic                    out_valid,
    output vid_mm_pkg::pix_t        out_pix
);

    vid_mm_pkg::lane_t lane;
    logic              xfer;
    logic              last_lane;

    assign last_lane = (lane == vid_mm_pkg::lane_t'(vid_mm_pkg::PIX_PER_WORD - 1));

    // head word offered while the buffer is not empty
    assign out_valid = buf_valid;
    assign out_pix   = buf_word[lane * vid_mm_pkg::PIX_W +: vid_mm_pkg::PIX_W];
    assign xfer      = out_valid && out_ready;
    // word leaves the buffer with its final lane
    assign buf_pop   = xfer && last_lane;

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            lane <= '0;
        end else if (xfer) begin
            lane <= last_lane ? '0 : lane + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vid_mm_top.sv
/*
 * vid_mm_top: pixel packer, burst writer, burst reader and
 * pixel unpacker around an external word memory
 */
`timescale 1ns/1ns
`default_nettype none

module vid_mm_top #(
    parameter int BURST_LEN   = 4,
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                     mm_tras_inst,
    input  wire                     rst_n,
    // raster pixel input
    input  wire                     vsync,
    input  wire                     de,
    input  wire vid_mm_pkg::pix_t   pix,
    // memory write port
    output logic                    aw_valid,
    output vid_mm_pkg::mm_aw_t      aw,
    input  wire                     aw_ready,
    output logic                    w_valid,
    output vid_mm_pkg::mm_w_t       w,
    input  wire                     w_ready,
    output logic                    overflow,
    // memory read port
    input  wire                     rd_enable,
    input  wire vid_mm_pkg::addr_t  frame_words,
    output logic                    ar_valid,
    output vid_mm_pkg::mm_ar_t      ar,
    input  wire                     ar_ready,
    input  wire                     r_valid,
    input  wire vid_mm_pkg::mm_r_t  r,
    output logic                    r_ready,
    // pixel output
    output logic                    out_valid,
    output vid_mm_pkg::pix_t        out_pix,
    input  wire                     out_ready
);

    // packer to writer
    logic              word_valid;
    vid_mm_pkg::word_t word;
    logic              frame_start;
    // reader to unpacker
    logic              buf_valid;
    vid_mm_pkg::word_t buf_word;
    logic              buf_pop;

    pixel_packer u_pixel_packer (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .vsync        (vsync),
        .de           (de),
        .pix          (pix),
        .word_valid   (word_valid),
        .word         (word),
        .frame_start  (frame_start)
    );

    burst_writer #(
        .BURST_LEN   (BURST_LEN),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_burst_writer (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .word_valid   (word_valid),
        .word         (word),
        .frame_start  (frame_start),
        .aw_ready     (aw_ready),
        .w_ready      (w_ready),
        .aw_valid     (aw_valid),
        .aw           (aw),
        .w_valid      (w_valid),
        .w            (w),
        .overflow     (overflow)
    );

    burst_reader #(
        .BURST_LEN   (BURST_LEN),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_burst_reader (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .rd_enable    (rd_enable),
        .frame_words  (frame_words),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r            (r),
        .buf_pop      (buf_pop),
        .ar_valid     (ar_valid),
        .ar           (ar),
        .r_ready      (r_ready),
        .buf_valid    (buf_valid),
        .buf_word     (buf_word)
    );

    pixel_unpacker u_pixel_unpacker (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .buf_valid    (buf_valid),
        .buf_word     (buf_word),
        .out_ready    (out_ready),
        .buf_pop      (buf_pop),
        .out_valid    (out_valid),
        .out_pix      (out_pix)
    );

endmodule

`default_nettype wire

// File: verification/vid_mm_assertions.sv
/*
 * valid/payload stability on aw, w and ar, and
 * w last on the final beat of every write burst
 */
`timescale 1ns/1ns
`default_nettype none

module vid_mm_assertions #(
    parameter int BURST_LEN = 4
) (
    input wire                     mm_tras_inst,
    input wire                     rst_n,
    input wire                     aw_valid,
    input wire                     aw_ready,
    input wire vid_mm_pkg::mm_aw_t aw,
    input wire                     w_valid,
    input wire                     w_ready,
    input wire vid_mm_pkg::mm_w_t  w,
    input wire                     ar_valid,
    input wire                     ar_ready,
    input wire vid_mm_pkg::mm_ar_t ar
);

    vid_mm_pkg::blen_t beat;
    // number of failed properties so far
    int                fails = 0;

    // beat number inside the current write burst
    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (w_valid && w_ready) begin
            beat <= w.last ? '0 : beat + 1'b1;
        end
    end

    aw_hold: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else begin
            fails++;
            $error("aw dropped or changed before its transfer");
        end

    w_hold: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else begin
            fails++;
            $error("w dropped or changed before its transfer");
        end

    ar_hold: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            fails++;
            $error("ar dropped or changed before its transfer");
        end

    // last exactly on beat BURST_LEN
    w_last: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        w_valid && w_ready |-> (w.last == (beat == vid_mm_pkg::blen_t'(BURST_LEN - 1))))
        else begin
            fails++;
            $error("w last does not match the burst length");
        end

endmodule

bind vid_mm_top vid_mm_assertions #(
    .BURST_LEN (BURST_LEN)
) u_vid_mm_assertions (
    .mm_tras_inst (mm_tras_inst),
    .rst_n        (rst_n),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .aw           (aw),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .w            (w),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar           (ar)
);

`default_nettype wire

// File: verification/vid_mm_tb.sv
/*
 * testbench for vid_mm_top: clock, reset, trace reader,
 * burst memory model with random back-pressure, stimulus and checks
 */
`timescale 1ns/1ns
`default_nettype none

module vid_mm_tb;

    localparam int BURST_LEN   = 4;
    localparam int QUEUE_DEPTH = 16;
    localparam int PPW         = vid_mm_pkg::PIX_PER_WORD;
    localparam int TIMEOUT     = 3000;

    logic                   mm_tras_inst = 1'b0;
    logic                   rst_n;
    logic                   vsync;
    logic                   de;
    vid_mm_pkg::pix_t       pix;
    logic                   rd_enable;
    vid_mm_pkg::addr_t      frame_words;
    // driven by the memory model
    logic                   aw_ready  = 1'b0;
    logic                   w_ready   = 1'b0;
    logic                   ar_ready  = 1'b0;
    logic                   r_valid   = 1'b0;
    vid_mm_pkg::mm_r_t      r         = '0;
    logic                   out_ready = 1'b0;
    // DUT outputs
    logic                   aw_valid;
    vid_mm_pkg::mm_aw_t     aw;
    logic                   w_valid;
    vid_mm_pkg::mm_w_t      w;
    logic                   overflow;
    logic                   ar_valid;
    vid_mm_pkg::mm_ar_t     ar;
    logic                   r_ready;
    logic                   out_valid;
    vid_mm_pkg::pix_t       out_pix;

    logic [15:0]            trace [0:511];
    vid_mm_pkg::word_t      mem [4096];
    vid_mm_pkg::pix_t       got [$];
    logic [12:0]            fa;
    logic [31:0]            rnd = 32'd50580;
    logic                   wthr = 1'b0;
    logic                   othr = 1'b0;
    logic                   vsync_q;
    // memory model burst state
    logic                   wr_busy;
    logic                   rd_busy;
    vid_mm_pkg::addr_t      wr_addr;
    vid_mm_pkg::addr_t      rd_addr;
    vid_mm_pkg::addr_t      wr_beat;
    vid_mm_pkg::addr_t      rd_beat;
    vid_mm_pkg::addr_t      exp_waddr;
    vid_mm_pkg::addr_t      exp_raddr;
    int                     bursts_done = 0;
    int                     mem_errors  = 0;
    int                     errors      = 0;
    int                     tests_run   = 0;
    int                     tests_pass  = 0;
    logic                   aborted     = 1'b0;

    vid_mm_top #(
        .BURST_LEN   (BURST_LEN),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_vid_mm_top (.*);

    always #4 mm_tras_inst = ~mm_tras_inst;

    // vsync as the DUT took it at the last rising edge
    always @(posedge mm_tras_inst) begin
        vsync_q <= vsync;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // every field carries the full word address
    function automatic vid_mm_pkg::word_t fill_word(input vid_mm_pkg::addr_t a);
        return {4'hd, a, 4'h5, a, 4'ha, a, 4'h3, a};
    endfunction

    function automatic logic [15:0] trace_at(input int idx);
        return trace[9'(idx)];
    endfunction

    // memory model and output sink, all decisions on the falling edge
    always @(negedge mm_tras_inst) begin
        if (!rst_n) begin
            for (fa = '0; fa < 13'd4096; fa++) begin
                mem[fa[11:0]] = fill_word(fa[11:0]);
            end
            wr_busy     = 1'b0;
            rd_busy     = 1'b0;
            exp_waddr   = '0;
            exp_raddr   = '0;
            bursts_done = 0;
            aw_ready    = 1'b0;
            w_ready     = 1'b0;
            ar_ready    = 1'b0;
            r_valid     = 1'b0;
            out_ready   = 1'b0;
            got.delete();
        end else begin
            rnd = lcg_next(rnd);
            // new frame writes from address 0 again
            if (vsync_q) begin
                exp_waddr = '0;
            end
            w_ready = wr_busy && (!wthr || rnd[29:28] != 2'b00);
            if (w_valid && w_ready) begin
                mem[wr_addr + wr_beat] = w.data;
                assert (w.last == (wr_beat == vid_mm_pkg::addr_t'(BURST_LEN - 1))) else begin
                    $display("Error: %0t w.last got %b expected %b", $time, w.last,
                             wr_beat == vid_mm_pkg::addr_t'(BURST_LEN - 1));
                    mem_errors++;
                end
                wr_beat = wr_beat + 1'b1;
                if (w.last) begin
                    wr_busy = 1'b0;
                    bursts_done++;
                end
            end
            aw_ready = !wr_busy && (!wthr || rnd[31:30] != 2'b00);
            if (aw_valid && aw_ready) begin
                assert (aw.addr == exp_waddr) else begin
                    $display("Error: %0t aw.addr got %0d expected %0d",
                             $time, aw.addr, exp_waddr);
                    mem_errors++;
                end
                assert (aw.len == vid_mm_pkg::blen_t'(BURST_LEN)) else begin
                    $display("Error: %0t aw.len got %0d expected %0d",
                             $time, aw.len, BURST_LEN);
                    mem_errors++;
                end
                wr_busy   = 1'b1;
                wr_addr   = aw.addr;
                wr_beat   = '0;
                exp_waddr = exp_waddr + vid_mm_pkg::addr_t'(BURST_LEN);
            end
            // r beat offered until taken
            if (rd_busy) begin
                r_valid = 1'b1;
                r.data  = mem[rd_addr + rd_beat];
                r.last  = (rd_beat == vid_mm_pkg::addr_t'(BURST_LEN - 1));
                if (r_ready) begin
                    rd_beat = rd_beat + 1'b1;
                    rd_busy = !r.last;
                end
            end else begin
                r_valid = 1'b0;
            end
            ar_ready = !rd_busy && (!wthr || rnd[25:24] != 2'b00);
            if (ar_valid && ar_ready) begin
                assert (ar.addr == exp_raddr) else begin
                    $display("Error: %0t ar.addr got %0d expected %0d",
                             $time, ar.addr, exp_raddr);
                    mem_errors++;
                end
                assert (ar.len == vid_mm_pkg::blen_t'(BURST_LEN)) else begin
                    $display("Error: %0t ar.len got %0d expected %0d",
                             $time, ar.len, BURST_LEN);
                    mem_errors++;
                end
                rd_busy = 1'b1;
                rd_addr = ar.addr;
                rd_beat = '0;
                // read region wraps at the frame size
                if (int'(exp_raddr) + BURST_LEN >= int'(frame_words)) begin
                    exp_raddr = '0;
                end else begin
                    exp_raddr = exp_raddr + vid_mm_pkg::addr_t'(BURST_LEN);
                end
            end
            out_ready = !othr || rnd[27:26] != 2'b00;
            if (out_valid && out_ready) begin
                got.push_back(out_pix);
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] got_v,
                               input logic [63:0] exp_v);
        assert (got_v === exp_v) else begin
            $display("Error: %0t %s got %h expected %h", $time, name, got_v, exp_v);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge mm_tras_inst);
        rst_n     = 1'b0;
        vsync     = 1'b0;
        de        = 1'b0;
        rd_enable = 1'b0;
        repeat (4) @(negedge mm_tras_inst);
        rst_n = 1'b1;
    endtask

    // vsync pulse, then one pixel per cycle
    task automatic send_frame(input int first, input int count);
        int i;
        @(negedge mm_tras_inst);
        vsync = 1'b1;
        @(negedge mm_tras_inst);
        vsync = 1'b0;
        for (i = 0; i < count; i++) begin
            de  = 1'b1;
            pix = trace_at(first + i);
            @(negedge mm_tras_inst);
        end
        de = 1'b0;
    endtask

    task automatic wait_bursts(input int target, output logic ok);
        int t;
        ok = 1'b0;
        for (t = 0; t < TIMEOUT && !ok; t++) begin
            @(negedge mm_tras_inst);
            ok = (bursts_done >= target);
        end
    endtask

    task automatic wait_pixels(input int target, output logic ok);
        int t;
        ok = 1'b0;
        for (t = 0; t < TIMEOUT && !ok; t++) begin
            @(negedge mm_tras_inst);
            ok = (got.size() >= target);
        end
    endtask

    task automatic run_test(input int base, output int next_base);
        int id;
        int frames;
        int n_in;
        int n_exp;
        int fpix;
        int words;
        int first;
        int err_start;
        int f;
        int k;
        int j;
        logic ok;
        vid_mm_pkg::word_t exp_word;
        id          = int'(trace_at(base));
        frame_words = vid_mm_pkg::addr_t'(trace_at(base + 1));
        wthr        = 1'(trace_at(base + 2));
        othr        = 1'(trace_at(base + 3));
        frames      = int'(trace_at(base + 4));
        n_in        = int'(trace_at(base + 5));
        n_exp       = int'(trace_at(base + 6));
        next_base   = base + 7 + n_in + n_exp;
        fpix        = n_in / frames;
        words       = fpix / PPW;
        err_start   = errors + mem_errors;
        ok          = 1'b1;
        tests_run++;
        apply_reset();
        // idle outputs before any stimulus
        repeat (3) begin
            @(negedge mm_tras_inst);
            check_value("aw_valid", 64'(aw_valid), 64'(0));
            check_value("w_valid", 64'(w_valid), 64'(0));
            check_value("ar_valid", 64'(ar_valid), 64'(0));
            check_value("r_ready", 64'(r_ready), 64'(0));
            check_value("out_valid", 64'(out_valid), 64'(0));
            check_value("overflow", 64'(overflow), 64'(0));
        end
        for (f = 0; f < frames && ok; f++) begin
            send_frame(base + 7 + f * fpix, fpix);
            wait_bursts((f + 1) * words / BURST_LEN, ok);
            if (!ok) begin
                $display("test %0d: timeout, write bursts of frame %0d never completed", id, f);
            end
        end
        if (ok) begin
            // last frame sits at word 0 upward, pixel 4k in lane 0
            first = base + 7 + (frames - 1) * fpix;
            for (k = 0; k < words; k++) begin
                for (j = 0; j < PPW; j++) begin
                    exp_word[j * vid_mm_pkg::PIX_W +: vid_mm_pkg::PIX_W] =
                        trace_at(first + k * PPW + j);
                end
                check_value($sformatf("mem[%0d]", k), mem[vid_mm_pkg::addr_t'(k)], exp_word);
            end
            check_value("overflow", 64'(overflow), 64'(0));
            @(negedge mm_tras_inst);
            rd_enable = 1'b1;
            wait_pixels(n_exp, ok);
            @(negedge mm_tras_inst);
            rd_enable = 1'b0;
            if (!ok) begin
                $display("test %0d: timeout, only %0d of %0d pixels came out",
                         id, got.size(), n_exp);
            end
        end
        if (ok) begin
            for (k = 0; k < n_exp; k++) begin
                check_value($sformatf("out_pix[%0d]", k), 64'(got[k]),
                            64'(trace_at(base + 7 + n_in + k)));
            end
        end else begin
            errors++;
            aborted = 1'b1;
        end
        if (ok && errors + mem_errors == err_start) begin
            tests_pass++;
        end
        $display("test %0d: frame_words %0d, aw/w throttle %0d, out throttle %0d, %0d errors",
                 id, frame_words, wthr, othr, errors + mem_errors - err_start);
    endtask

    initial begin
        int base;
        int next_base;
        int total;
        rst_n       = 1'b0;
        vsync       = 1'b0;
        de          = 1'b0;
        pix         = '0;
        rd_enable   = 1'b0;
        frame_words = '0;
        $readmemh("verification/vid_mm_trace.txt", trace);
        base = 0;
        while (base < 500 && trace_at(base) != 16'h0000 && !aborted) begin
            run_test(base, next_base);
            base = next_base;
        end
        total = errors + mem_errors + u_vid_mm_top.u_vid_mm_assertions.fails;
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_pass, tests_run - tests_pass, total);
        if (total == 0 && !aborted && tests_run > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/vid_mm_trace.txt
// per test: id frame_words aw_w_throttle out_throttle frames n_in n_exp,
// then n_in input pixels, then n_exp expected output pixels; id 0000 ends
0001 0008 0000 0000 0001 0020 0020
0100 0101 0102 0103 0104 0105 0106 0107 0108 0109 010a 010b 010c 010d 010e 010f
0110 0111 0112 0113 0114 0115 0116 0117 0118 0119 011a 011b 011c 011d 011e 011f
0100 0101 0102 0103 0104 0105 0106 0107 0108 0109 010a 010b 010c 010d 010e 010f
0110 0111 0112 0113 0114 0115 0116 0117 0118 0119 011a 011b 011c 011d 011e 011f
0002 0008 0001 0000 0001 0020 0020
2a00 2a01 2a02 2a03 2a04 2a05 2a06 2a07 2a08 2a09 2a0a 2a0b 2a0c 2a0d 2a0e 2a0f
2a10 2a11 2a12 2a13 2a14 2a15 2a16 2a17 2a18 2a19 2a1a 2a1b 2a1c 2a1d 2a1e 2a1f
2a00 2a01 2a02 2a03 2a04 2a05 2a06 2a07 2a08 2a09 2a0a 2a0b 2a0c 2a0d 2a0e 2a0f
2a10 2a11 2a12 2a13 2a14 2a15 2a16 2a17 2a18 2a19 2a1a 2a1b 2a1c 2a1d 2a1e 2a1f
0003 0008 0000 0001 0001 0020 0020
3c00 3c01 3c02 3c03 3c04 3c05 3c06 3c07 3c08 3c09 3c0a 3c0b 3c0c 3c0d 3c0e 3c0f
3c10 3c11 3c12 3c13 3c14 3c15 3c16 3c17 3c18 3c19 3c1a 3c1b 3c1c 3c1d 3c1e 3c1f
3c00 3c01 3c02 3c03 3c04 3c05 3c06 3c07 3c08 3c09 3c0a 3c0b 3c0c 3c0d 3c0e 3c0f
3c10 3c11 3c12 3c13 3c14 3c15 3c16 3c17 3c18 3c19 3c1a 3c1b 3c1c 3c1d 3c1e 3c1f
0004 0008 0000 0000 0002 0040 0030
4400 4401 4402 4403 4404 4405 4406 4407 4408 4409 440a 440b 440c 440d 440e 440f
4410 4411 4412 4413 4414 4415 4416 4417 4418 4419 441a 441b 441c 441d 441e 441f
4800 4801 4802 4803 4804 4805 4806 4807 4808 4809 480a 480b 480c 480d 480e 480f
4810 4811 4812 4813 4814 4815 4816 4817 4818 4819 481a 481b 481c 481d 481e 481f
4800 4801 4802 4803 4804 4805 4806 4807 4808 4809 480a 480b 480c 480d 480e 480f
4810 4811 4812 4813 4814 4815 4816 4817 4818 4819 481a 481b 481c 481d 481e 481f
4800 4801 4802 4803 4804 4805 4806 4807 4808 4809 480a 480b 480c 480d 480e 480f
0000

// File: vlog.f
rtl/vid_mm_pkg.sv
rtl/pixel_packer.sv
rtl/burst_writer.sv
rtl/burst_reader.sv
rtl/pixel_unpacker.sv
rtl/vid_mm_top.sv
verification/vid_mm_assertions.sv
verification/vid_mm_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the frame buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module vid_mm_tb \
    -Mdir obj_dir -o vid_mm_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vid_mm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1
